/* hdl/cx4_pkg.sv */
package cx4_pkg;

  //////////////////////////////
  // widths

  typedef logic [12:0] host_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [11:0] ram_addr_t;
  typedef logic [22:0] bus_addr_t;   // bank 23:16 joined to 14:0

  localparam int unsigned DATRAM_DEPTH = 3072;
  localparam ram_addr_t   DATRAM_LIMIT = 12'hC00;   // first host address past ram

  //////////////////////////////
  // address map

  localparam logic [7:0] MMIO_PAGE    = 8'hFA;   // 0x1f40 - 0x1f5f
  localparam logic [4:0] STATUS_FIRST = 5'h13;   // 0x1f53 and up

  localparam logic [4:0] REG_DMASRC_L = 5'h00;
  localparam logic [4:0] REG_DMASRC_M = 5'h01;
  localparam logic [4:0] REG_DMASRC_H = 5'h02;
  localparam logic [4:0] REG_DMALEN_L = 5'h03;
  localparam logic [4:0] REG_DMALEN_H = 5'h04;
  localparam logic [4:0] REG_DMATGT_L = 5'h05;
  localparam logic [4:0] REG_DMATGT_M = 5'h06;
  localparam logic [4:0] REG_DMATGT_H = 5'h07;   // writing this one starts dma

  localparam logic [4:0] REG_CFG50    = 5'h10;
  localparam logic [4:0] REG_CFG51    = 5'h11;
  localparam logic [4:0] REG_CFG52    = 5'h12;

  //////////////////////////////
  // masks and reset values

  localparam byte_t CFG50_MASK  = 8'h77;
  localparam byte_t CFG50_RESET = 8'h33;
  localparam logic  CFG52_RESET = 1'b1;

  // nWR low samples before a rise is taken as a write
  localparam int unsigned WR_LOW_MIN = 5;

  //////////////////////////////
  // structs

  typedef struct packed {
    logic [23:0] src;
    logic [15:0] len;
    logic [23:0] tgt;   // only 11:0 reach the ram
  } dma_cfg_t;

  typedef struct packed {
    logic      we;
    ram_addr_t addr;
    byte_t     wdata;
  } ram_port_t;

endpackage

/* hdl/cx4_datram.sv */
`timescale 1ns/1ps

module cx4_datram (
  input  logic               CLK,
  input  cx4_pkg::ram_port_t port_a,
  input  cx4_pkg::ram_port_t port_b,
  output cx4_pkg::byte_t     rdata_a,
  output cx4_pkg::byte_t     rdata_b
);

  cx4_pkg::byte_t mem [cx4_pkg::DATRAM_DEPTH];

  //////////////////////////////
  // two ports, read before write

  always_ff @(posedge CLK) begin
    rdata_a <= mem[port_a.addr];
    rdata_b <= mem[port_b.addr];
    if (port_a.we) begin
      mem[port_a.addr] <= port_a.wdata;   // host side
    end
    if (port_b.we) begin
      mem[port_b.addr] <= port_b.wdata;   // dma side, wins a same-address clash
    end
  end

endmodule

/* hdl/cx4_dma.sv */
`timescale 1ns/1ps

module cx4_dma (
  input  logic               CLK,
  input  logic               rst,
  input  cx4_pkg::dma_cfg_t  dma_cfg,
  input  logic               dma_start,
  input  logic               bus_rdy,
  input  cx4_pkg::byte_t     bus_di,
  output logic               bus_rrq,
  output cx4_pkg::bus_addr_t bus_addr,
  output cx4_pkg::ram_port_t dma_port,
  output logic               busy
);

  typedef enum logic [4:0] {
    ST_IDLE  = 5'b00001,
    ST_START = 5'b00010,
    ST_WAIT  = 5'b00100,
    ST_ADDR  = 5'b01000,
    ST_END   = 5'b10000
  } state_t;

  state_t             state;
  logic               ram_we;
  logic               byte_rdy;
  logic [15:0]        count;
  logic [23:0]        src_ptr;
  cx4_pkg::ram_addr_t tgt_ptr;

  // rdy only counts once our own request has dropped
  assign byte_rdy = (state == ST_WAIT) & ~bus_rrq & bus_rdy;

  assign bus_addr = {src_ptr[23:16], src_ptr[14:0]};   // bit 15 skipped
  assign dma_port = '{we: ram_we, addr: tgt_ptr, wdata: bus_di};

  //////////////////////////////
  // control

  always_ff @(posedge CLK) begin
    if (rst) begin
      state   <= ST_IDLE;
      busy    <= 1'b0;
      bus_rrq <= 1'b0;
      ram_we  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (dma_start) begin
            state <= ST_START;
          end
        end
        ST_START: begin
          busy    <= 1'b1;
          bus_rrq <= 1'b1;   // first byte
          state   <= ST_WAIT;
        end
        ST_WAIT: begin
          bus_rrq <= 1'b0;
          if (byte_rdy) begin
            ram_we <= 1'b1;
            state  <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          ram_we <= 1'b0;
          if (count == 16'h0000) begin
            busy  <= 1'b0;
            state <= ST_END;
          end else begin
            bus_rrq <= 1'b1;   // next byte
            state   <= ST_WAIT;
          end
        end
        ST_END: state <= ST_IDLE;   // one cycle turnaround
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // pointers and count

  always_ff @(posedge CLK) begin
    case (state)
      ST_START: begin
        src_ptr <= dma_cfg.src;
        tgt_ptr <= dma_cfg.tgt[11:0];
        count   <= dma_cfg.len;   // 0 gives 65536 bytes
      end
      ST_WAIT: begin
        if (byte_rdy) begin
          count <= count - 16'd1;
        end
      end
      ST_ADDR: begin
        src_ptr <= src_ptr + 24'd1;
        tgt_ptr <= tgt_ptr + 12'd1;   // wraps in 4k
      end
      default: ;
    endcase
  end

endmodule

/* hdl/cx4_host_regs.sv */
`timescale 1ns/1ps

module cx4_host_regs (
  input  logic                CLK,
  input  logic                rst,
  input  logic                cs,
  input  cx4_pkg::host_addr_t addr,
  input  cx4_pkg::byte_t      di,
  input  logic                n_wr,
  input  cx4_pkg::byte_t      ram_rdata,
  input  logic                busy,
  output cx4_pkg::byte_t      do_data,
  output cx4_pkg::dma_cfg_t   dma_cfg,
  output logic                dma_start,
  output cx4_pkg::ram_port_t  host_port
);

  logic [cx4_pkg::WR_LOW_MIN:0] n_wr_sreg;
  logic                         wr_en;
  cx4_pkg::byte_t               di_q;

  logic page_hit;
  logic ram_sel;
  logic mmio_sel;
  logic status_sel;
  logic mmio_wr;

  cx4_pkg::dma_cfg_t cfg_q;
  cx4_pkg::byte_t    cfg50_q;
  logic              cfg51_q;
  logic              cfg52_q;

  cx4_pkg::byte_t mmio_rd_q;
  cx4_pkg::byte_t status_byte;

  //////////////////////////////
  // write strobe

  always_ff @(posedge CLK) begin
    if (rst) begin
      n_wr_sreg <= '1;   // looks like a long high, no false strobe
    end else begin
      n_wr_sreg <= {n_wr_sreg[cx4_pkg::WR_LOW_MIN-1:0], n_wr};
    end
  end

  // data lags one cycle, host holds it through the rise
  always_ff @(posedge CLK) begin
    di_q <= di;
  end

  assign wr_en = (n_wr_sreg == {{cx4_pkg::WR_LOW_MIN{1'b0}}, 1'b1});

  //////////////////////////////
  // address decode

  assign page_hit   = (addr[12:5] == cx4_pkg::MMIO_PAGE);
  assign ram_sel    = cs & (addr < {1'b0, cx4_pkg::DATRAM_LIMIT});
  assign mmio_sel   = cs & page_hit & (addr[4:0] < cx4_pkg::STATUS_FIRST);
  assign status_sel = cs & page_hit & (addr[4:0] >= cx4_pkg::STATUS_FIRST);
  assign mmio_wr    = mmio_sel & wr_en;

  assign host_port = '{we: ram_sel & wr_en, addr: addr[11:0], wdata: di_q};

  //////////////////////////////
  // register file

  always_ff @(posedge CLK) begin
    if (rst) begin
      cfg_q   <= '0;
      cfg50_q <= cx4_pkg::CFG50_RESET;
      cfg51_q <= 1'b0;
      cfg52_q <= cx4_pkg::CFG52_RESET;
    end else if (mmio_wr) begin
      case (addr[4:0])
        cx4_pkg::REG_DMASRC_L: cfg_q.src[7:0]   <= di_q;
        cx4_pkg::REG_DMASRC_M: cfg_q.src[15:8]  <= di_q;
        cx4_pkg::REG_DMASRC_H: cfg_q.src[23:16] <= di_q;
        cx4_pkg::REG_DMALEN_L: cfg_q.len[7:0]   <= di_q;
        cx4_pkg::REG_DMALEN_H: cfg_q.len[15:8]  <= di_q;
        cx4_pkg::REG_DMATGT_L: cfg_q.tgt[7:0]   <= di_q;
        cx4_pkg::REG_DMATGT_M: cfg_q.tgt[15:8]  <= di_q;
        cx4_pkg::REG_DMATGT_H: cfg_q.tgt[23:16] <= di_q;
        cx4_pkg::REG_CFG50:    cfg50_q <= di_q & cx4_pkg::CFG50_MASK;
        cx4_pkg::REG_CFG51:    cfg51_q <= di_q[0];
        cx4_pkg::REG_CFG52:    cfg52_q <= di_q[0];
        default: ;   // 0x08-0x0f ignore writes
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      dma_start <= 1'b0;
    end else begin
      dma_start <= mmio_wr & (addr[4:0] == cx4_pkg::REG_DMATGT_H);
    end
  end

  assign dma_cfg = cfg_q;

  //////////////////////////////
  // read path

  always_ff @(posedge CLK) begin
    case (addr[4:0])
      cx4_pkg::REG_DMASRC_L: mmio_rd_q <= cfg_q.src[7:0];
      cx4_pkg::REG_DMASRC_M: mmio_rd_q <= cfg_q.src[15:8];
      cx4_pkg::REG_DMASRC_H: mmio_rd_q <= cfg_q.src[23:16];
      cx4_pkg::REG_DMALEN_L: mmio_rd_q <= cfg_q.len[7:0];
      cx4_pkg::REG_DMALEN_H: mmio_rd_q <= cfg_q.len[15:8];
      cx4_pkg::REG_DMATGT_L: mmio_rd_q <= cfg_q.tgt[7:0];
      cx4_pkg::REG_DMATGT_M: mmio_rd_q <= cfg_q.tgt[15:8];
      cx4_pkg::REG_DMATGT_H: mmio_rd_q <= cfg_q.tgt[23:16];
      cx4_pkg::REG_CFG50:    mmio_rd_q <= cfg50_q;
      cx4_pkg::REG_CFG51:    mmio_rd_q <= {7'b0, cfg51_q};
      cx4_pkg::REG_CFG52:    mmio_rd_q <= {7'b0, cfg52_q};
      default:               mmio_rd_q <= 8'h00;   // dropped slots
    endcase
  end

  assign status_byte = {1'b0, busy, 4'b0000, ~busy, 1'b0};

  always_comb begin
    if (ram_sel) begin
      do_data = ram_rdata;
    end else if (mmio_sel) begin
      do_data = mmio_rd_q;
    end else if (status_sel) begin
      do_data = status_byte;
    end else begin
      do_data = 8'h00;
    end
  end

endmodule

/* hdl/cx4_top.sv */
`timescale 1ns/1ps

module cx4_top (
  input  logic                CLK,
  input  logic                rst,
  input  logic                CS,
  input  cx4_pkg::host_addr_t ADDR,
  input  cx4_pkg::byte_t      DI,
  input  logic                nWR,
  output cx4_pkg::byte_t      DO,
  output cx4_pkg::bus_addr_t  BUS_ADDR,
  output logic                BUS_RRQ,
  input  logic                BUS_RDY,
  input  cx4_pkg::byte_t      BUS_DI,
  output logic                cx4_active
);

  cx4_pkg::dma_cfg_t  dma_cfg;
  logic               dma_start;
  logic               dma_busy;
  cx4_pkg::ram_port_t host_port;
  cx4_pkg::ram_port_t dma_port;
  cx4_pkg::byte_t     ram_rdata;

  assign cx4_active = dma_busy;   // only the dma engine can be busy

  cx4_host_regs u_host_regs (
    .CLK       (CLK),
    .rst       (rst),
    .cs        (CS),
    .addr      (ADDR),
    .di        (DI),
    .n_wr      (nWR),
    .ram_rdata (ram_rdata),
    .busy      (dma_busy),
    .do_data   (DO),
    .dma_cfg   (dma_cfg),
    .dma_start (dma_start),
    .host_port (host_port)
  );

  cx4_dma u_dma (
    .CLK       (CLK),
    .rst       (rst),
    .dma_cfg   (dma_cfg),
    .dma_start (dma_start),
    .bus_rdy   (BUS_RDY),
    .bus_di    (BUS_DI),
    .bus_rrq   (BUS_RRQ),
    .bus_addr  (BUS_ADDR),
    .dma_port  (dma_port),
    .busy      (dma_busy)
  );

  cx4_datram u_datram (
    .CLK     (CLK),
    .port_a  (host_port),
    .port_b  (dma_port),
    .rdata_a (ram_rdata),
    .rdata_b ()   // dma never reads back
  );

endmodule

/* verif/cx4_dma_checker.sv */
`timescale 1ns/1ps

module cx4_dma_checker (
  input logic               CLK,
  input logic               rst,
  input logic               bus_rrq,
  input logic               busy,
  input cx4_pkg::ram_port_t dma_port
);

  //////////////////////////////
  // request pulse

  rrq_single_cycle: assert property (@(posedge CLK) disable iff (rst) bus_rrq |=> !bus_rrq)
    else $error("bus_rrq held high for two cycles");

  rrq_low_after_rst: assert property (@(posedge CLK) rst |=> !bus_rrq)
    else $error("bus_rrq high right after reset");

  //////////////////////////////
  // activity only while busy

  rrq_while_busy: assert property (@(posedge CLK) disable iff (rst) bus_rrq |-> busy)
    else $error("bus_rrq raised while dma idle");

  write_while_busy: assert property (@(posedge CLK) disable iff (rst) dma_port.we |-> busy)
    else $error("dma ram write while dma idle");

endmodule

/* verif/cx4_bus_model.sv */
`timescale 1ns/1ps

module cx4_bus_model (
  input  logic               CLK,
  input  logic               rst,
  input  logic               bus_rrq,
  input  cx4_pkg::bus_addr_t bus_addr,
  output logic               bus_rdy,
  output cx4_pkg::byte_t     bus_di
);

  cx4_pkg::bus_addr_t req_log [$];   // every request, in order
  cx4_pkg::bus_addr_t req_addr;
  integer             seed = 76;
  int                 delay;

  // memory contents, xor of the three address bytes
  function automatic cx4_pkg::byte_t mem_byte(input cx4_pkg::bus_addr_t a);
    return {1'b0, a[22:16]} ^ a[15:8] ^ a[7:0];
  endfunction

  initial begin
    bus_rdy = 1'b1;
    bus_di  = 8'h00;
    forever begin
      @(posedge CLK);
      #5;
      if (!rst && bus_rrq) begin
        req_addr = bus_addr;
        req_log.push_back(req_addr);
        bus_rdy = 1'b0;                                 // request seen
        delay   = 1 + ($unsigned($random(seed)) % 6);   // 1 to 6 cycles
        repeat (delay) @(posedge CLK);
        #5;
        bus_di  = mem_byte(req_addr);
        bus_rdy = 1'b1;                                 // data held until next request
      end
    end
  end

endmodule

/* verif/cx4_tb.sv */
`timescale 1ns/1ps

module cx4_tb;

  // 5 transfers x 16 bytes x 10 cycles is 800, host traffic about 2500
  localparam int MAX_CYCLES = 20000;
  localparam int N_XFERS    = 5;
  localparam int N_RAM      = 16;

  logic                CLK;
  logic                rst;
  logic                CS;
  cx4_pkg::host_addr_t ADDR;
  cx4_pkg::byte_t      DI;
  logic                nWR;
  cx4_pkg::byte_t      DO;
  cx4_pkg::bus_addr_t  BUS_ADDR;
  logic                BUS_RRQ;
  logic                BUS_RDY;
  cx4_pkg::byte_t      BUS_DI;
  logic                cx4_active;

  integer             seed = 76;
  int                 cycles = 0;
  int                 log_rd = 0;
  int                 busy_reads = 0;
  cx4_pkg::bus_addr_t exp_addr [$];    // expected request addresses
  cx4_pkg::byte_t     ram_model [int];

  cx4_top DUT (.*);

  cx4_bus_model bus (
    .CLK(CLK), .rst(rst), .bus_rrq(BUS_RRQ), .bus_addr(BUS_ADDR),
    .bus_rdy(BUS_RDY), .bus_di(BUS_DI)
  );

  bind cx4_dma cx4_dma_checker dma_checker (.*);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////
  // reference functions

  function automatic cx4_pkg::bus_addr_t map_addr(input logic [23:0] src);
    return {src[23:16], src[14:0]};   // bit 15 skipped
  endfunction

  function automatic cx4_pkg::byte_t bus_byte(input cx4_pkg::bus_addr_t a);
    return {1'b0, a[22:16]} ^ a[15:8] ^ a[7:0];
  endfunction

  function automatic cx4_pkg::byte_t status_ref(input logic busy);
    return busy ? 8'h40 : 8'h02;
  endfunction

  function automatic cx4_pkg::host_addr_t reg_addr(input logic [4:0] off);
    return {cx4_pkg::MMIO_PAGE, off};
  endfunction

  function automatic cx4_pkg::byte_t rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  //////////////////////////////
  // checks

  task automatic stop_with_fail(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input cx4_pkg::byte_t got, input cx4_pkg::byte_t exp,
                            input string what);
    if (got !== exp) begin
      stop_with_fail($sformatf("MISMATCH at %0t: %s got 0x%02h, expected 0x%02h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_bus_addr(input cx4_pkg::bus_addr_t got, input cx4_pkg::bus_addr_t exp,
                                input string what);
    if (got !== exp) begin
      stop_with_fail($sformatf("MISMATCH at %0t: %s got 0x%06h, expected 0x%06h",
                               $time, what, got, exp));
    end
  endtask

  // request log against expected addresses
  always @(negedge CLK) begin
    if (bus.req_log.size() > log_rd) begin
      if (exp_addr.size() == 0) begin
        stop_with_fail("bus request seen while no transfer was expected");
      end else begin
        check_bus_addr(bus.req_log[log_rd], exp_addr.pop_front(), "request address");
      end
      log_rd++;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      stop_with_fail("timeout: DMA never finished");
    end
  end

  //////////////////////////////
  // host access

  task automatic host_write(input cx4_pkg::host_addr_t a, input cx4_pkg::byte_t d);
    @(posedge CLK);
    #5;
    CS   = 1'b1;
    ADDR = a;
    DI   = d;
    nWR  = 1'b0;
    repeat (8) @(posedge CLK);
    #5;
    nWR = 1'b1;   // DI held through the rise
    repeat (3) @(posedge CLK);
    #5;
    CS = 1'b0;
  endtask

  task automatic host_read(input cx4_pkg::host_addr_t a, output cx4_pkg::byte_t d);
    @(posedge CLK);
    #5;
    CS   = 1'b1;
    ADDR = a;
    repeat (2) @(posedge CLK);
    #5;
    d  = DO;
    CS = 1'b0;
  endtask

  task automatic read_status();
    logic           act_issue;
    cx4_pkg::byte_t got;
    @(posedge CLK);
    #5;
    act_issue = cx4_active;
    CS        = 1'b1;
    ADDR      = reg_addr(cx4_pkg::STATUS_FIRST);
    repeat (2) @(posedge CLK);
    #5;
    got = DO;
    CS  = 1'b0;
    if (act_issue === cx4_active) begin   // skip reads across the busy edge
      check_byte(got, status_ref(cx4_active), "status");
      if (cx4_active) begin
        busy_reads++;
      end
    end
  endtask

  task automatic run_transfer(input int k);
    logic [31:0]    r;
    logic [23:0]    src;
    logic [23:0]    tgt;
    int             nbytes;
    int             base;
    int             waited;
    cx4_pkg::byte_t got;
    cx4_pkg::byte_t regs [8];
    r      = $random(seed);
    src    = r[23:0];
    r      = $random(seed);
    tgt    = {r[31:20], 12'(r[19:0] % 20'hBF0)};
    nbytes = 1 + ($unsigned($random(seed)) % 16);
    regs   = '{src[7:0], src[15:8], src[23:16], 8'(nbytes), 8'h00,
               tgt[7:0], tgt[15:8], tgt[23:16]};
    for (int i = 0; i < nbytes; i++) begin
      exp_addr.push_back(map_addr(src + 24'(i)));
    end
    base = bus.req_log.size();
    for (int i = 0; i < 8; i++) begin
      host_write(reg_addr(5'(i)), regs[i]);   // target high byte last, starts dma
    end
    waited = 0;
    while (cx4_active !== 1'b1) begin
      if (waited == 8) begin
        stop_with_fail($sformatf("transfer %0d: DMA did not start after the target write", k));
      end
      @(posedge CLK);
      #5;
      waited++;
    end
    while (cx4_active === 1'b1) begin
      read_status();
    end
    read_status();
    if (bus.req_log.size() - base != nbytes) begin
      stop_with_fail($sformatf("MISMATCH at %0t: transfer %0d made %0d requests, expected %0d",
                               $time, k, bus.req_log.size() - base, nbytes));
    end
    for (int i = 0; i < 8; i++) begin
      host_read(reg_addr(5'(i)), got);
      check_byte(got, regs[i], "dma register readback");
    end
    for (int i = 0; i < nbytes; i++) begin
      host_read({1'b0, tgt[11:0] + 12'(i)}, got);
      check_byte(got, bus_byte(map_addr(src + 24'(i))), "dma data");
    end
  endtask

  //////////////////////////////
  // test sequence

  initial begin
    cx4_pkg::byte_t got;
    cx4_pkg::byte_t d;
    logic [31:0]    r;
    logic [11:0]    a;
    rst  = 1'b1;
    CS   = 1'b0;
    ADDR = '0;
    DI   = 8'h00;
    nWR  = 1'b1;
    repeat (3) @(posedge CLK);
    #5;
    rst = 1'b0;

    if (BUS_RRQ !== 1'b0) begin
      stop_with_fail("BUS_RRQ is not low after reset");
    end
    read_status();
    for (int i = 0; i < 8; i++) begin
      host_read(reg_addr(5'(i)), got);
      check_byte(got, 8'h00, "dma register after reset");
    end
    host_read(reg_addr(cx4_pkg::REG_CFG50), got);
    check_byte(got, 8'h33, "cfg50 after reset");
    host_read(reg_addr(cx4_pkg::REG_CFG51), got);
    check_byte(got, 8'h00, "cfg51 after reset");
    host_read(reg_addr(cx4_pkg::REG_CFG52), got);
    check_byte(got, 8'h01, "cfg52 after reset");

    for (int k = 0; k < 4; k++) begin
      d = rand_byte();
      host_write(reg_addr(cx4_pkg::REG_CFG50), d);
      host_read(reg_addr(cx4_pkg::REG_CFG50), got);
      check_byte(got, d & 8'h77, "cfg50 readback");
      host_write(reg_addr(cx4_pkg::REG_CFG51), d);
      host_read(reg_addr(cx4_pkg::REG_CFG51), got);
      check_byte(got, {7'b0, d[0]}, "cfg51 readback");
      host_write(reg_addr(cx4_pkg::REG_CFG52), ~d);
      host_read(reg_addr(cx4_pkg::REG_CFG52), got);
      check_byte(got, {7'b0, ~d[0]}, "cfg52 readback");
    end
    for (int i = 8; i < 16; i++) begin
      host_write(reg_addr(5'(i)), rand_byte());
      host_read(reg_addr(5'(i)), got);
      check_byte(got, 8'h00, "dropped slot");
    end

    for (int i = 0; i < N_RAM; i++) begin
      r = $random(seed);
      a = 12'(r[19:0] % 20'hC00);
      host_write({1'b0, a}, r[31:24]);
      ram_model[int'(a)] = r[31:24];   // later write to same address wins
    end
    foreach (ram_model[idx]) begin
      host_read(13'(idx), got);
      check_byte(got, ram_model[idx], "data ram");
    end

    for (int k = 0; k < N_XFERS; k++) begin
      run_transfer(k);
    end

    if (busy_reads == 0) begin
      stop_with_fail("no status read landed while the DMA was busy");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* flist.f */
hdl/cx4_pkg.sv
hdl/cx4_datram.sv
hdl/cx4_dma.sv
hdl/cx4_host_regs.sv
hdl/cx4_top.sv
verif/cx4_dma_checker.sv
verif/cx4_bus_model.sv
verif/cx4_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the cx4 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cx4_tb -f flist.f -o cx4_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/cx4_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1
